// ==== eth_mid_cfg.svh ====
`ifndef ETH_MID_CFG_SVH
`define ETH_MID_CFG_SVH

// ------------------------------
// bus geometry
// ------------------------------
`define ETH_DAT_W 16
`define ETH_ADR_W 12
// word address bit that selects the slot memory
`define ETH_ADR_MEM_BIT 11

// ------------------------------
// transmit slot and timing
// ------------------------------
`define ETH_SLOT_AW 10
`define ETH_SLOT_DEPTH (1 << `ETH_SLOT_AW)
`define ETH_IFG 12

// moderation limits after reset
`define ETH_INTR_RST_VAL 32'd2500000

`endif

// ==== eth_mid_reg_pkg.sv ====
`default_nettype none

`include "eth_mid_cfg.svh"

package eth_mid_reg_pkg;

  typedef logic [`ETH_DAT_W-1:0] reg_word_t;
  typedef logic [1:0] reg_sel_t;
  typedef logic [`ETH_ADR_W-1:0] bus_adr_t;

  // register word offsets
  typedef enum logic [7:0] {
    REG_CNT0   = 8'h02,
    REG_CNT1   = 8'h03,
    REG_CNT2   = 8'h04,
    REG_CNT3   = 8'h05,
    REG_STATUS = 8'h08,
    REG_TX_WR  = 8'h18,
    REG_TX_RD  = 8'h1a,
    REG_CLR_LO = 8'h40,
    REG_CLR_HI = 8'h41,
    REG_SET_LO = 8'h42,
    REG_SET_HI = 8'h43
  } reg_idx_t;

  // one-cycle register access from the bus decoder
  typedef struct packed {
    logic      rd;
    logic      wr;
    reg_idx_t  idx;
    reg_word_t dat;
    reg_sel_t  sel;
  } reg_access_t;

  typedef logic [31:0] intr_val_t;

endpackage

`default_nettype wire

// ==== eth_mid_tx_pkg.sv ====
`default_nettype none

`include "eth_mid_cfg.svh"

package eth_mid_tx_pkg;

  typedef logic [`ETH_SLOT_AW-1:0] tx_ptr_t;

  // bus side of the slot memory
  typedef struct packed {
    logic                       en;
    logic                       we;
    tx_ptr_t                    addr;
    eth_mid_reg_pkg::reg_word_t dat;
    eth_mid_reg_pkg::reg_sel_t  sel;
  } slot_access_t;

  typedef logic [7:0] gmii_byte_t;

  typedef struct packed {
    logic       en;
    gmii_byte_t data;
  } gmii_tx_t;

  typedef logic [15:0] frame_len_t;

  typedef enum logic [2:0] {TX_IDLE, TX_LEN, TX_PRE, TX_DATA, TX_GAP} tx_state_e;

endpackage

`default_nettype wire

// ==== wb_slave_decode.sv ====
`default_nettype none

`include "eth_mid_cfg.svh"

module wb_slave_decode (
  input  wire logic                          clk_125,
  input  wire logic                          sys_rst,
  input  wire logic                          wb_cyc_i,
  input  wire logic                          wb_stb_i,
  input  wire logic                          wb_we_i,
  input  wire eth_mid_reg_pkg::bus_adr_t     wb_adr_i,
  input  wire eth_mid_reg_pkg::reg_word_t    wb_dat_i,
  input  wire eth_mid_reg_pkg::reg_sel_t     wb_sel_i,
  output eth_mid_reg_pkg::reg_word_t         wb_dat_o,
  output logic                               wb_ack_o,
  output eth_mid_reg_pkg::reg_access_t       reg_acc_o,
  output eth_mid_tx_pkg::slot_access_t       slot_acc_o,
  input  wire eth_mid_reg_pkg::reg_word_t    reg_rdata_i,
  input  wire eth_mid_reg_pkg::reg_word_t    slot_rdata_i
);

  import eth_mid_reg_pkg::*;
  import eth_mid_tx_pkg::*;

  logic acc;
  logic mem_hit;
  logic mem_sel_q;

  // new access only while ack is not out yet
  assign acc     = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign mem_hit = wb_adr_i[`ETH_ADR_MEM_BIT];

  // ------------------------------
  // access pulses
  // ------------------------------
  always_comb begin
    reg_acc_o.rd  = acc & ~mem_hit & ~wb_we_i;
    reg_acc_o.wr  = acc & ~mem_hit & wb_we_i;
    // offsets above 0xff land on an unlisted index and read as zero
    if (wb_adr_i[10:8] == 3'd0) begin
      reg_acc_o.idx = reg_idx_t'(wb_adr_i[7:0]);
    end else begin
      reg_acc_o.idx = reg_idx_t'(8'h00);
    end
    reg_acc_o.dat = wb_dat_i;
    reg_acc_o.sel = wb_sel_i;

    slot_acc_o.en   = acc & mem_hit;
    slot_acc_o.we   = wb_we_i;
    slot_acc_o.addr = tx_ptr_t'(wb_adr_i[`ETH_SLOT_AW-1:0]);
    slot_acc_o.dat  = wb_dat_i;
    slot_acc_o.sel  = wb_sel_i;
  end

  // ------------------------------
  // ack and read mux
  // ------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= acc;
    end
  end

  always_ff @(posedge clk_125) begin
    if (acc) begin
      mem_sel_q <= mem_hit;
    end
  end

  assign wb_dat_o = mem_sel_q ? slot_rdata_i : reg_rdata_i;

  // master keeps the cycle up until it sees ack
  ack_after_held_access: assert property (
    @(posedge clk_125) disable iff (sys_rst)
    wb_ack_o |-> $past(acc) && wb_cyc_i && wb_stb_i
  );

endmodule

`default_nettype wire

// ==== ctrl_regs.sv ====
`default_nettype none

`include "eth_mid_cfg.svh"

module ctrl_regs (
  input  wire logic                          clk_125,
  input  wire logic                          sys_rst,
  input  wire eth_mid_reg_pkg::reg_access_t  reg_acc_i,
  output eth_mid_reg_pkg::reg_word_t         reg_rdata_o,
  input  wire eth_mid_tx_pkg::tx_ptr_t       tx_rd_ptr_i,
  output eth_mid_tx_pkg::tx_ptr_t            tx_wr_ptr_o,
  input  wire logic                          intr_i,
  output eth_mid_reg_pkg::intr_val_t         clr_val_o,
  output eth_mid_reg_pkg::intr_val_t         set_val_o,
  output logic                               rearm_o,
  output logic [7:0]                         led_o
);

  import eth_mid_reg_pkg::*;
  import eth_mid_tx_pkg::*;

  logic [63:0] cnt_q;
  // status bits 7:4 and 2:0 around the live interrupt bit
  logic [6:0]  status_q;
  logic [7:0]  status;

  // host byte order puts byte 0 on the upper lane
  function automatic reg_word_t host_swap(reg_word_t val);
    return {val[7:0], val[15:8]};
  endfunction

  function automatic reg_word_t lane_merge(reg_word_t old_val, reg_word_t bus_dat,
                                           reg_sel_t sel);
    reg_word_t val;
    val = old_val;
    if (sel[1]) val[7:0] = bus_dat[15:8];
    if (sel[0]) val[15:8] = bus_dat[7:0];
    return val;
  endfunction

  assign status = {status_q[6:3], intr_i, status_q[2:0]};
  assign led_o  = ~status;

  // ------------------------------
  // counter and register writes
  // ------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      cnt_q       <= '0;
      status_q    <= '0;
      tx_wr_ptr_o <= '0;
      clr_val_o   <= `ETH_INTR_RST_VAL;
      set_val_o   <= `ETH_INTR_RST_VAL;
      rearm_o     <= 1'b0;
    end else begin
      cnt_q   <= cnt_q + 64'd1;
      rearm_o <= 1'b0;
      if (reg_acc_i.wr) begin
        case (reg_acc_i.idx)
          REG_STATUS: begin
            if (reg_acc_i.sel[1]) begin
              status_q <= {reg_acc_i.dat[15:12], reg_acc_i.dat[10:8]};
              // bit 3 written low restarts moderation
              rearm_o  <= ~reg_acc_i.dat[11];
            end
          end
          REG_TX_WR: tx_wr_ptr_o <= tx_ptr_t'(lane_merge(reg_word_t'(tx_wr_ptr_o),
                                                         reg_acc_i.dat, reg_acc_i.sel));
          REG_CLR_LO: clr_val_o[15:0] <= lane_merge(clr_val_o[15:0], reg_acc_i.dat,
                                                    reg_acc_i.sel);
          REG_CLR_HI: clr_val_o[31:16] <= lane_merge(clr_val_o[31:16], reg_acc_i.dat,
                                                     reg_acc_i.sel);
          REG_SET_LO: set_val_o[15:0] <= lane_merge(set_val_o[15:0], reg_acc_i.dat,
                                                    reg_acc_i.sel);
          REG_SET_HI: set_val_o[31:16] <= lane_merge(set_val_o[31:16], reg_acc_i.dat,
                                                     reg_acc_i.sel);
          default: ;
        endcase
      end
    end
  end

  // ------------------------------
  // read-back
  // ------------------------------
  always_ff @(posedge clk_125) begin
    if (reg_acc_i.rd) begin
      case (reg_acc_i.idx)
        REG_CNT0:   reg_rdata_o <= host_swap(cnt_q[15:0]);
        REG_CNT1:   reg_rdata_o <= host_swap(cnt_q[31:16]);
        REG_CNT2:   reg_rdata_o <= host_swap(cnt_q[47:32]);
        REG_CNT3:   reg_rdata_o <= host_swap(cnt_q[63:48]);
        REG_STATUS: reg_rdata_o <= {status, 8'h00};
        REG_TX_WR:  reg_rdata_o <= host_swap(reg_word_t'(tx_wr_ptr_o));
        REG_TX_RD:  reg_rdata_o <= host_swap(reg_word_t'(tx_rd_ptr_i));
        REG_CLR_LO: reg_rdata_o <= host_swap(clr_val_o[15:0]);
        REG_CLR_HI: reg_rdata_o <= host_swap(clr_val_o[31:16]);
        REG_SET_LO: reg_rdata_o <= host_swap(set_val_o[15:0]);
        REG_SET_HI: reg_rdata_o <= host_swap(set_val_o[31:16]);
        default:    reg_rdata_o <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== intr_moderator.sv ====
`default_nettype none

module intr_moderator (
  input  wire logic                        clk_125,
  input  wire logic                        sys_rst,
  input  wire logic                        frame_done_i,
  input  wire logic                        rearm_i,
  input  wire eth_mid_reg_pkg::intr_val_t  clr_val_i,
  input  wire eth_mid_reg_pkg::intr_val_t  set_val_i,
  output logic                             intr_o
);

  import eth_mid_reg_pkg::*;

  intr_val_t holdoff_q;
  intr_val_t hold_q;

  // ------------------------------
  // hold-off after rearm
  // ------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      holdoff_q <= '0;
    end else if (rearm_i) begin
      holdoff_q <= clr_val_i;
    end else if (holdoff_q != '0) begin
      holdoff_q <= holdoff_q - 32'd1;
    end
  end

  // set on a frame, self-clearing after the hold time
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      intr_o <= 1'b0;
      hold_q <= '0;
    end else if (rearm_i) begin
      intr_o <= 1'b0;
      hold_q <= '0;
    end else if (intr_o) begin
      if (hold_q == set_val_i) begin
        intr_o <= 1'b0;
        hold_q <= '0;
      end else begin
        hold_q <= hold_q + 32'd1;
      end
    end else if (frame_done_i && holdoff_q == '0) begin
      intr_o <= 1'b1;
      hold_q <= '0;
    end
  end

  no_intr_during_holdoff: assert property (
    @(posedge clk_125) disable iff (sys_rst)
    $rose(intr_o) |-> $past(holdoff_q == '0)
  );

endmodule

`default_nettype wire

// ==== tx_slot_sender.sv ====
`default_nettype none

`include "eth_mid_cfg.svh"

module tx_slot_sender (
  input  wire logic                          clk_125,
  input  wire logic                          sys_rst,
  input  wire eth_mid_tx_pkg::slot_access_t  slot_acc_i,
  output eth_mid_reg_pkg::reg_word_t         slot_rdata_o,
  input  wire eth_mid_tx_pkg::tx_ptr_t       tx_wr_ptr_i,
  output eth_mid_tx_pkg::tx_ptr_t            tx_rd_ptr_o,
  output eth_mid_tx_pkg::gmii_tx_t           gmii_o,
  output logic                               frame_done_o
);

  import eth_mid_reg_pkg::*;
  import eth_mid_tx_pkg::*;

  reg_word_t  mem [`ETH_SLOT_DEPTH];
  reg_word_t  q_b;
  tx_ptr_t    fetch_q;
  tx_state_e  state_q;
  frame_len_t cnt_q;
  frame_len_t len_q;

  // ------------------------------
  // port a belongs to the host
  // ------------------------------
  always_ff @(posedge clk_125) begin
    if (slot_acc_i.en) begin
      if (slot_acc_i.we) begin
        if (slot_acc_i.sel[1]) mem[slot_acc_i.addr][15:8] <= slot_acc_i.dat[15:8];
        if (slot_acc_i.sel[0]) mem[slot_acc_i.addr][7:0] <= slot_acc_i.dat[7:0];
      end
      slot_rdata_o <= mem[slot_acc_i.addr];
    end
  end

  // port b belongs to the sender
  always_ff @(posedge clk_125) begin
    q_b <= mem[fetch_q];
  end

  // ------------------------------
  // frame sender
  // ------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      state_q      <= TX_IDLE;
      cnt_q        <= '0;
      len_q        <= '0;
      fetch_q      <= '0;
      tx_rd_ptr_o  <= '0;
      gmii_o       <= '0;
      frame_done_o <= 1'b0;
    end else begin
      gmii_o       <= '0;
      frame_done_o <= 1'b0;
      case (state_q)
        TX_IDLE: begin
          fetch_q <= tx_rd_ptr_o;
          cnt_q   <= '0;
          if (tx_rd_ptr_o != tx_wr_ptr_i) state_q <= TX_LEN;
        end
        TX_LEN: begin
          // wait out the port b read latency
          if (cnt_q == 16'd1) begin
            len_q   <= q_b;
            fetch_q <= fetch_q + 1'b1;
            cnt_q   <= '0;
            state_q <= TX_PRE;
          end else begin
            cnt_q <= cnt_q + 16'd1;
          end
        end
        TX_PRE: begin
          gmii_o.en   <= 1'b1;
          gmii_o.data <= (cnt_q == 16'd7) ? 8'hd5 : 8'h55;
          if (cnt_q == 16'd7) begin
            cnt_q   <= '0;
            state_q <= TX_DATA;
          end else begin
            cnt_q <= cnt_q + 16'd1;
          end
        end
        TX_DATA: begin
          gmii_o.en   <= 1'b1;
          gmii_o.data <= cnt_q[0] ? q_b[15:8] : q_b[7:0];
          // next word is on q_b two cycles after the low byte
          if (!cnt_q[0]) fetch_q <= fetch_q + 1'b1;
          if (cnt_q == len_q - 16'd1) begin
            cnt_q   <= '0;
            state_q <= TX_GAP;
          end else begin
            cnt_q <= cnt_q + 16'd1;
          end
        end
        TX_GAP: begin
          tx_rd_ptr_o  <= fetch_q;
          frame_done_o <= (cnt_q == 16'd0);
          if (cnt_q == frame_len_t'(`ETH_IFG - 1)) begin
            state_q <= TX_IDLE;
          end else begin
            cnt_q <= cnt_q + 16'd1;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // output is one cycle behind the state
  gap_keeps_en_low: assert property (
    @(posedge clk_125) disable iff (sys_rst)
    $past(state_q) == TX_GAP |-> !gmii_o.en
  );

endmodule

`default_nettype wire

// ==== ethpipe_mid.sv ====
`default_nettype none

module ethpipe_mid (
  input  wire logic                        clk_125,
  input  wire logic                        sys_rst,
  input  wire logic                        wb_cyc_i,
  input  wire logic                        wb_stb_i,
  input  wire logic                        wb_we_i,
  input  wire eth_mid_reg_pkg::bus_adr_t   wb_adr_i,
  input  wire eth_mid_reg_pkg::reg_word_t  wb_dat_i,
  input  wire eth_mid_reg_pkg::reg_sel_t   wb_sel_i,
  output eth_mid_reg_pkg::reg_word_t       wb_dat_o,
  output logic                             wb_ack_o,
  output logic                             gmii_tx_en_o,
  output logic [7:0]                       gmii_txd_o,
  output logic                             sys_intr_o,
  output logic [7:0]                       led_o
);

  import eth_mid_reg_pkg::*;
  import eth_mid_tx_pkg::*;

  reg_access_t  reg_acc;
  slot_access_t slot_acc;
  reg_word_t    reg_rdata;
  reg_word_t    slot_rdata;
  tx_ptr_t      tx_wr_ptr;
  tx_ptr_t      tx_rd_ptr;
  intr_val_t    clr_val;
  intr_val_t    set_val;
  logic         rearm;
  logic         frame_done;
  logic         intr;
  gmii_tx_t     gmii;

  // ------------------------------
  // host side
  // ------------------------------
  wb_slave_decode u_decode (
    .clk_125(clk_125), .sys_rst(sys_rst),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
    .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
    .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
    .reg_acc_o(reg_acc), .slot_acc_o(slot_acc),
    .reg_rdata_i(reg_rdata), .slot_rdata_i(slot_rdata)
  );

  ctrl_regs u_regs (
    .clk_125(clk_125), .sys_rst(sys_rst),
    .reg_acc_i(reg_acc), .reg_rdata_o(reg_rdata),
    .tx_rd_ptr_i(tx_rd_ptr), .tx_wr_ptr_o(tx_wr_ptr),
    .intr_i(intr), .clr_val_o(clr_val), .set_val_o(set_val),
    .rearm_o(rearm), .led_o(led_o)
  );

  intr_moderator u_intr (
    .clk_125(clk_125), .sys_rst(sys_rst),
    .frame_done_i(frame_done), .rearm_i(rearm),
    .clr_val_i(clr_val), .set_val_i(set_val), .intr_o(intr)
  );

  // phy side
  tx_slot_sender u_sender (
    .clk_125(clk_125), .sys_rst(sys_rst),
    .slot_acc_i(slot_acc), .slot_rdata_o(slot_rdata),
    .tx_wr_ptr_i(tx_wr_ptr), .tx_rd_ptr_o(tx_rd_ptr),
    .gmii_o(gmii), .frame_done_o(frame_done)
  );

  assign gmii_tx_en_o = gmii.en;
  assign gmii_txd_o   = gmii.data;
  assign sys_intr_o   = intr;

endmodule

`default_nettype wire

// ==== tb_ethpipe_mid.sv ====
`default_nettype none

`include "eth_mid_cfg.svh"

module tb_ethpipe_mid;

  import eth_mid_reg_pkg::*;
  import eth_mid_tx_pkg::*;

  localparam int CLK_PER = 20;
  // leaves the write pointer at 1020 so later frames wrap
  localparam int BIG_LEN = 2037;
  localparam intr_val_t RST_LIM = `ETH_INTR_RST_VAL;
  // frames with preamble, gap and start-up, then about 1300 bus accesses
  localparam int FRAME_CYC = BIG_LEN + 5 * 64 + 6 * (8 + `ETH_IFG + 4);
  localparam int CYCLE_LIMIT = FRAME_CYC + 3 * 1300 + 100 + 500;

  logic        clk_125 = 1'b0;
  logic        sys_rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  bus_adr_t    wb_adr;
  reg_word_t   wb_dat_w;
  reg_sel_t    wb_sel;
  reg_word_t   wb_dat_r;
  logic        wb_ack;
  logic        gmii_tx_en;
  gmii_byte_t  gmii_txd;
  logic        sys_intr;
  logic [7:0]  led;

  logic [31:0] lfsr_q = 32'hfd3b8f60;
  int          err_cnt = 0;
  int          chk_cnt = 0;
  int          cycle_cnt = 0;
  int          run_len = 0;
  time         cnt_base;
  time         last_acc_t;
  time         last_end_t;
  tx_ptr_t     wr_ptr = '0;
  gmii_byte_t  exp_bytes[$];
  gmii_byte_t  rx_bytes[$];
  int          rx_lens[$];

  ethpipe_mid u_ethpipe_mid (
    .clk_125(clk_125), .sys_rst(sys_rst),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
    .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_sel_i(wb_sel),
    .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
    .gmii_tx_en_o(gmii_tx_en), .gmii_txd_o(gmii_txd),
    .sys_intr_o(sys_intr), .led_o(led)
  );

  always #(CLK_PER / 2) clk_125 = ~clk_125;

  always @(posedge clk_125) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("timeout, DUT stopped responding");
      $display("Test failed");
      $finish;
    end
  end

  // ------------------------------
  // gmii monitor
  // ------------------------------
  always @(negedge clk_125) begin
    if (gmii_tx_en === 1'b1) begin
      rx_bytes.push_back(gmii_txd);
      run_len++;
    end else if (run_len != 0) begin
      rx_lens.push_back(run_len);
      run_len = 0;
      last_end_t = $time;
    end
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic reg_word_t host_order(reg_word_t v);
    return {v[7:0], v[15:8]};
  endfunction

  function automatic bus_adr_t reg_adr(reg_idx_t idx);
    return bus_adr_t'(idx);
  endfunction

  function automatic bus_adr_t slot_adr(tx_ptr_t p);
    return {2'b10, p};
  endfunction

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_word(reg_word_t got, reg_word_t exp, string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_ptr(tx_ptr_t got, tx_ptr_t exp, string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_byte(gmii_byte_t got, gmii_byte_t exp, string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(logic got, logic exp, string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail at %0t: %s, got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // ------------------------------
  // bus and frame helpers
  // ------------------------------
  task automatic wait_ack(output reg_word_t rdat);
    @(posedge clk_125);
    last_acc_t = $time;
    #2;
    while (wb_ack !== 1'b1) begin
      @(posedge clk_125);
      #2;
    end
    rdat = wb_dat_r;
    // cycle stays up through the ack cycle
    @(posedge clk_125);
    #2;
    check_bit(wb_ack, 1'b0, "ack lasts one cycle");
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic wb_write(bus_adr_t adr, reg_word_t dat, reg_sel_t sel);
    reg_word_t unused;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b1;
    wb_adr = adr;
    wb_dat_w = dat;
    wb_sel = sel;
    wait_ack(unused);
  endtask

  task automatic wb_read(bus_adr_t adr, output reg_word_t dat);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b0;
    wb_adr = adr;
    wb_dat_w = '0;
    wb_sel = 2'b11;
    wait_ack(dat);
  endtask

  task automatic load_frame(frame_len_t len);
    gmii_byte_t lo;
    gmii_byte_t hi;
    wb_write(slot_adr(wr_ptr), len, 2'b11);
    wr_ptr = wr_ptr + tx_ptr_t'(1);
    for (int i = 0; i < len; i += 2) begin
      lo = gmii_byte_t'(take_bits(8));
      hi = gmii_byte_t'(take_bits(8));
      exp_bytes.push_back(lo);
      if (i + 1 < len) exp_bytes.push_back(hi);
      wb_write(slot_adr(wr_ptr), {hi, lo}, 2'b11);
      wr_ptr = wr_ptr + tx_ptr_t'(1);
    end
  endtask

  task automatic commit_wr_ptr();
    wb_write(reg_adr(REG_TX_WR), host_order(reg_word_t'(wr_ptr)), 2'b11);
  endtask

  task automatic expect_frame(frame_len_t len, tx_ptr_t start);
    reg_word_t  rd;
    gmii_byte_t e;
    int         run;
    while (rx_lens.size() == 0) @(negedge clk_125);
    @(posedge clk_125);
    #2;
    run = rx_lens.pop_front();
    check_word(reg_word_t'(run), len + 16'd8, "enable length");
    for (int i = 0; i < run; i++) begin
      if (i < 7) e = 8'h55;
      else if (i == 7) e = 8'hd5;
      else if (exp_bytes.size() != 0) e = exp_bytes.pop_front();
      else e = 8'h00;
      check_byte(rx_bytes.pop_front(), e, "gmii byte");
    end
    exp_bytes.delete();
    wb_read(reg_adr(REG_TX_RD), rd);
    check_ptr(tx_ptr_t'(host_order(rd)),
              tx_ptr_t'(int'(start) + 1 + (int'(len) + 1) / 2), "read pointer");
  endtask

  task automatic test_summary(string name, int errs_before);
    $display("%s finished, %0d errors", name, err_cnt - errs_before);
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic reset_and_lanes();
    reg_word_t rd;
    int        errs;
    errs = err_cnt;
    wb_read(reg_adr(REG_CLR_LO), rd);
    check_word(rd, host_order(RST_LIM[15:0]), "clr low after reset");
    wb_read(reg_adr(REG_CLR_HI), rd);
    check_word(rd, host_order(RST_LIM[31:16]), "clr high after reset");
    wb_read(reg_adr(REG_SET_LO), rd);
    check_word(rd, host_order(RST_LIM[15:0]), "set low after reset");
    wb_read(reg_adr(REG_SET_HI), rd);
    check_word(rd, host_order(RST_LIM[31:16]), "set high after reset");
    wb_read(reg_adr(REG_TX_WR), rd);
    check_word(rd, 16'h0000, "write pointer after reset");
    wb_read(reg_adr(REG_TX_RD), rd);
    check_word(rd, 16'h0000, "read pointer after reset");
    // value 0x1234, then byte 0 to 0xab, then byte 1 to 0xcd
    wb_write(reg_adr(REG_CLR_LO), 16'h3412, 2'b11);
    wb_read(reg_adr(REG_CLR_LO), rd);
    check_word(rd, 16'h3412, "full word write");
    wb_write(reg_adr(REG_CLR_LO), 16'hab77, 2'b10);
    wb_read(reg_adr(REG_CLR_LO), rd);
    check_word(rd, 16'hab12, "byte 0 lane write");
    wb_write(reg_adr(REG_CLR_LO), 16'h77cd, 2'b01);
    wb_read(reg_adr(REG_CLR_LO), rd);
    check_word(rd, 16'habcd, "byte 1 lane write");
    wb_read(12'h007, rd);
    check_word(rd, 16'h0000, "unlisted offset 0x07");
    // low byte matches REG_CLR_LO, which holds a nonzero value here
    wb_read(12'h140, rd);
    check_word(rd, 16'h0000, "unlisted offset 0x140");
    test_summary("reset values and lanes", errs);
  endtask

  task automatic counter_reads();
    reg_word_t   a;
    reg_word_t   b;
    reg_word_t   rd;
    logic [63:0] cnt;
    int          errs;
    errs = err_cnt;
    wb_read(reg_adr(REG_CNT0), a);
    wb_read(reg_adr(REG_CNT0), b);
    check_word(host_order(b) - host_order(a), 16'd2, "counter delta");
    for (int k = 0; k < 4; k++) begin
      wb_read(bus_adr_t'(8'h02 + k), rd);
      cnt = (last_acc_t - cnt_base) / CLK_PER;
      check_word(rd, host_order(cnt[16 * k +: 16]), "counter word");
    end
    test_summary("counter", errs);
  endtask

  task automatic slot_memory_rw();
    reg_word_t words[16];
    reg_word_t rd;
    reg_word_t upd;
    int        errs;
    errs = err_cnt;
    for (int i = 0; i < 16; i++) begin
      words[i] = reg_word_t'(take_bits(16));
      wb_write(slot_adr(tx_ptr_t'(10'h3f0 + i)), words[i], 2'b11);
    end
    for (int i = 0; i < 16; i++) begin
      wb_read(slot_adr(tx_ptr_t'(10'h3f0 + i)), rd);
      check_word(rd, words[i], "slot word");
    end
    upd = reg_word_t'(take_bits(16));
    wb_write(slot_adr(10'h3f0), upd, 2'b10);
    wb_read(slot_adr(10'h3f0), rd);
    check_word(rd, {upd[15:8], words[0][7:0]}, "slot upper lane");
    test_summary("slot memory", errs);
  endtask

  task automatic frame_tx();
    tx_ptr_t    start;
    frame_len_t len;
    logic [4:0] r;
    int         errs;
    errs = err_cnt;
    start = wr_ptr;
    load_frame(frame_len_t'(BIG_LEN));
    commit_wr_ptr();
    expect_frame(frame_len_t'(BIG_LEN), start);
    for (int f = 0; f < 3; f++) begin
      r = 5'(take_bits(5));
      len = (f % 2 == 0) ? frame_len_t'(2 * r + 1) : frame_len_t'(2 * r + 2);
      start = wr_ptr;
      load_frame(len);
      commit_wr_ptr();
      expect_frame(len, start);
    end
    test_summary("frame transmission", errs);
  endtask

  task automatic intr_moderation();
    reg_word_t rd;
    tx_ptr_t   start;
    time       rearm_t;
    int        high_cyc;
    int        errs;
    errs = err_cnt;
    wb_write(reg_adr(REG_CLR_LO), host_order(16'd20), 2'b11);
    wb_write(reg_adr(REG_CLR_HI), 16'h0000, 2'b11);
    wb_write(reg_adr(REG_SET_LO), host_order(16'd5), 2'b11);
    wb_write(reg_adr(REG_SET_HI), 16'h0000, 2'b11);
    // frame ending inside the hold-off is dropped
    start = wr_ptr;
    load_frame(1);
    wb_write(reg_adr(REG_STATUS), 16'ha500, 2'b10);
    rearm_t = last_acc_t;
    commit_wr_ptr();
    expect_frame(1, start);
    check_bit(last_end_t - rearm_t < 20 * CLK_PER, 1'b1, "frame end inside hold-off");
    repeat (10) begin
      @(negedge clk_125);
      check_bit(sys_intr, 1'b0, "interrupt during hold-off");
    end
    @(posedge clk_125);
    #2;
    wb_read(reg_adr(REG_STATUS), rd);
    check_word(rd, 16'ha500, "status read-back");
    check_byte(led, ~8'ha5, "led against status");
    repeat (30) @(posedge clk_125);
    #2;
    start = wr_ptr;
    load_frame(1);
    commit_wr_ptr();
    while (sys_intr !== 1'b1) @(negedge clk_125);
    high_cyc = 0;
    while (sys_intr === 1'b1) begin
      high_cyc++;
      @(negedge clk_125);
    end
    check_word(reg_word_t'(high_cyc), 16'd6, "interrupt high cycles");
    expect_frame(1, start);
    test_summary("interrupt moderation", errs);
  endtask

  initial begin
    sys_rst = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    wb_sel = '0;
    repeat (10) @(posedge clk_125);
    #2;
    sys_rst = 1'b0;
    // counter reads zero at this edge
    @(posedge clk_125);
    cnt_base = $time;
    #2;
    reset_and_lanes();
    counter_reads();
    slot_memory_rw();
    frame_tx();
    intr_moderation();
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== ethpipe_mid.f ====
+incdir+.
eth_mid_reg_pkg.sv
eth_mid_tx_pkg.sv
wb_slave_decode.sv
ctrl_regs.sv
intr_moderator.sv
tx_slot_sender.sv
ethpipe_mid.sv
tb_ethpipe_mid.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal -f ethpipe_mid.f \
    --top-module tb_ethpipe_mid -o sim_tb; then
  echo "verilator build failed"
  exit 1
fi

if ! sim_out=$(./obj_dir/sim_tb 2>&1); then
  echo "$sim_out"
  echo "simulation exited with an error"
  exit 1
fi
echo "$sim_out"

if echo "$sim_out" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1
